// File: pulse_pkg.sv
`default_nettype none

package pulse_pkg;

   typedef logic [31:0] pulse_time_t;  // Count of clk_pll cycles
   typedef logic [6:0]  att_code_t;    // Attenuator step code
   typedef logic [7:0]  cpmg_count_t;  // CPMG repeats and current repeat index
   typedef logic [7:0]  block_time_t;  // Blocking window extension after pulse 2
   typedef logic [7:0]  axi_addr_t;    // AXI byte address
   typedef logic [31:0] axi_data_t;    // AXI data word
   typedef logic [1:0]  axi_resp_t;    // AXI response code

   // Shared by the write FSM and the read FSM of the register block
   typedef enum logic [1:0] {
      wr_idle,
      wr_resp,
      rd_idle,
      rd_data
   } axi_state_t;

   localparam axi_addr_t reg_ctrl         = 8'h00;  // pump, double, block
   localparam axi_addr_t reg_period       = 8'h04;
   localparam axi_addr_t reg_sync_up      = 8'h08;
   localparam axi_addr_t reg_p1width      = 8'h0C;
   localparam axi_addr_t reg_p2start      = 8'h10;
   localparam axi_addr_t reg_p2width      = 8'h14;
   localparam axi_addr_t reg_pbwidth      = 8'h18;
   localparam axi_addr_t reg_att_down     = 8'h1C;
   localparam axi_addr_t reg_att          = 8'h20;  // pp_pump, pp_probe, post_att
   localparam axi_addr_t reg_delay        = 8'h24;
   localparam axi_addr_t reg_offres_delay = 8'h28;
   localparam axi_addr_t reg_cpmg         = 8'h2C;  // pulse_block, cpmg

   localparam int reg_count = 12;  // Number of mapped words

   localparam int ctrl_pump   = 0;  // Bit positions in reg_ctrl
   localparam int ctrl_double = 1;
   localparam int ctrl_block  = 2;

   // Second attenuator opens this many cycles before sync ends
   localparam pulse_time_t att3_lead = 32'd30;

   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: pulse_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pulse_cfg_if import pulse_pkg::*; ();

   logic        pump;          // First pulse enable
   logic        double;        // Extra off-resonance pulse enable
   logic        block;         // Blocking switch enable
   pulse_time_t period;        // Last count of the period
   pulse_time_t sync_up;       // End of the second pulse
   pulse_time_t p1width;       // Width of the first pulse
   pulse_time_t p2start;       // Start of the second pulse
   pulse_time_t p2width;       // Width of each CPMG pulse
   pulse_time_t pbwidth;       // Width of the extra pulse
   pulse_time_t att_down;      // End of the probe attenuation window
   pulse_time_t delay;         // Gap between CPMG pulses
   pulse_time_t offres_delay;  // End of the extra pulse
   att_code_t   pp_pump;       // Main attenuator during pump
   att_code_t   pp_probe;      // Main attenuator during probe
   att_code_t   post_att;      // Second attenuator code
   block_time_t pulse_block;   // Blocking hold after sync_up
   cpmg_count_t cpmg;          // Number of extra CPMG pulses

   modport src (
      output pump, double, block,
      output period, sync_up, p1width, p2start, p2width, pbwidth,
      output att_down, delay, offres_delay,
      output pp_pump, pp_probe, post_att, pulse_block, cpmg
   );

   modport dst (
      input pump, double, block,
      input period, sync_up, p1width, p2start, p2width, pbwidth,
      input att_down, delay, offres_delay,
      input pp_pump, pp_probe, post_att, pulse_block, cpmg
   );

endinterface

`default_nettype wire

// File: pulse_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_regs import pulse_pkg::*; (
   input  logic       clk_pll,
   input  logic       resetn,       // Reset asserted high
   input  axi_addr_t  s_awaddr,
   input  logic       s_awvalid,
   output logic       s_awready,
   input  axi_data_t  s_wdata,
   input  logic [3:0] s_wstrb,
   input  logic       s_wvalid,
   output logic       s_wready,
   output axi_resp_t  s_bresp,
   output logic       s_bvalid,
   input  logic       s_bready,
   input  axi_addr_t  s_araddr,
   input  logic       s_arvalid,
   output logic       s_arready,
   output axi_data_t  s_rdata,
   output axi_resp_t  s_rresp,
   output logic       s_rvalid,
   input  logic       s_rready,
   input  logic       cycle_start,  // Count is 0, commit point
   pulse_cfg_if.src   cfg
);

   function automatic logic reg_hit(input axi_addr_t addr);
      case (addr)
         reg_ctrl, reg_period, reg_sync_up, reg_p1width,
         reg_p2start, reg_p2width, reg_pbwidth, reg_att_down,
         reg_att, reg_delay, reg_offres_delay, reg_cpmg: reg_hit = 1'b1;
         default: reg_hit = 1'b0;
      endcase
   endfunction

   axi_data_t  shadow [reg_count];  // Host-visible settings, word index is addr[5:2]
   axi_state_t wr_state;
   axi_state_t rd_state;
   logic       aw_taken;            // Address already held, waiting for data
   logic       w_taken;             // Data already held, waiting for address
   axi_addr_t  aw_addr_q;
   axi_data_t  w_data_q;
   logic [3:0] w_strb_q;
   logic       aw_hs;
   logic       w_hs;
   logic       wr_go;               // Both channels present this cycle
   axi_addr_t  wr_addr;
   axi_data_t  wr_data;
   logic [3:0] wr_strb;
   logic       ar_hs;

   assign s_awready = (wr_state == wr_idle) && !aw_taken;
   assign s_wready  = (wr_state == wr_idle) && !w_taken;
   assign s_bvalid  = (wr_state == wr_resp);
   assign aw_hs     = s_awvalid && s_awready;
   assign w_hs      = s_wvalid && s_wready;
   assign wr_go     = (aw_taken || aw_hs) && (w_taken || w_hs);
   assign wr_addr   = aw_taken ? aw_addr_q : s_awaddr;  // Held address wins
   assign wr_data   = w_taken ? w_data_q : s_wdata;
   assign wr_strb   = w_taken ? w_strb_q : s_wstrb;

   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         wr_state <= wr_idle;
         aw_taken <= 1'b0;
         w_taken  <= 1'b0;
      end else begin
         case (wr_state)
            wr_idle: begin
               if (wr_go) begin
                  wr_state <= wr_resp;  // bvalid next cycle
                  aw_taken <= 1'b0;
                  w_taken  <= 1'b0;
               end else begin
                  if (aw_hs) aw_taken <= 1'b1;
                  if (w_hs) w_taken <= 1'b1;
               end
            end
            wr_resp: if (s_bready) wr_state <= wr_idle;  // Hold response until taken
            default: wr_state <= wr_idle;
         endcase
      end
   end

   always_ff @(posedge clk_pll) begin
      if (aw_hs) aw_addr_q <= s_awaddr;
      if (w_hs) begin
         w_data_q <= s_wdata;
         w_strb_q <= s_wstrb;
      end
      if (wr_go) s_bresp <= reg_hit(wr_addr) ? resp_okay : resp_slverr;
   end

   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         for (int i = 0; i < reg_count; i++) shadow[i] <= '0;
      end else if (wr_go && reg_hit(wr_addr)) begin  // Unmapped write is dropped
         for (int b = 0; b < 4; b++) begin
            if (wr_strb[b]) shadow[wr_addr[5:2]][8*b +: 8] <= wr_data[8*b +: 8];
         end
      end
   end

   assign s_arready = (rd_state == rd_idle);
   assign s_rvalid  = (rd_state == rd_data);
   assign ar_hs     = s_arvalid && s_arready;

   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         rd_state <= rd_idle;
      end else begin
         case (rd_state)
            rd_idle: if (ar_hs) rd_state <= rd_data;
            rd_data: if (s_rready) rd_state <= rd_idle;
            default: rd_state <= rd_idle;
         endcase
      end
   end

   always_ff @(posedge clk_pll) begin
      if (ar_hs) begin
         s_rdata <= reg_hit(s_araddr) ? shadow[s_araddr[5:2]] : '0;  // Zero when unmapped
         s_rresp <= reg_hit(s_araddr) ? resp_okay : resp_slverr;
      end
   end

   // Whole set moves at once so a period never sees a mix
   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         cfg.pump         <= 1'b0;
         cfg.double       <= 1'b0;
         cfg.block        <= 1'b0;
         cfg.period       <= '0;
         cfg.sync_up      <= '0;
         cfg.p1width      <= '0;
         cfg.p2start      <= '0;
         cfg.p2width      <= '0;
         cfg.pbwidth      <= '0;
         cfg.att_down     <= '0;
         cfg.delay        <= '0;
         cfg.offres_delay <= '0;
         cfg.pp_pump      <= '0;
         cfg.pp_probe     <= '0;
         cfg.post_att     <= '0;
         cfg.pulse_block  <= '0;
         cfg.cpmg         <= '0;
      end else if (cycle_start) begin
         cfg.pump         <= shadow[reg_ctrl[5:2]][ctrl_pump];
         cfg.double       <= shadow[reg_ctrl[5:2]][ctrl_double];
         cfg.block        <= shadow[reg_ctrl[5:2]][ctrl_block];
         cfg.period       <= shadow[reg_period[5:2]];
         cfg.sync_up      <= shadow[reg_sync_up[5:2]];
         cfg.p1width      <= shadow[reg_p1width[5:2]];
         cfg.p2start      <= shadow[reg_p2start[5:2]];
         cfg.p2width      <= shadow[reg_p2width[5:2]];
         cfg.pbwidth      <= shadow[reg_pbwidth[5:2]];
         cfg.att_down     <= shadow[reg_att_down[5:2]];
         cfg.delay        <= shadow[reg_delay[5:2]];
         cfg.offres_delay <= shadow[reg_offres_delay[5:2]];
         cfg.pp_pump      <= shadow[reg_att[5:2]][6:0];
         cfg.pp_probe     <= shadow[reg_att[5:2]][14:8];
         cfg.post_att     <= shadow[reg_att[5:2]][22:16];
         cfg.pulse_block  <= shadow[reg_cpmg[5:2]][7:0];
         cfg.cpmg         <= shadow[reg_cpmg[5:2]][15:8];
      end
   end

endmodule

`default_nettype wire

// File: pulse_timer.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_timer import pulse_pkg::*; (
   input  logic        clk_pll,
   input  logic        resetn,       // Reset asserted high
   pulse_cfg_if.dst    cfg,
   output pulse_time_t count,        // Position inside the period
   output logic        cycle_start,  // First cycle of a period
   output pulse_time_t cpmg_start,   // Open edge of the current CPMG window
   output pulse_time_t cpmg_end      // Close edge of the current CPMG window
);

   cpmg_count_t cpmg_idx;  // Repeats already stepped this period

   assign cycle_start = (count == '0);

   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         count <= '0;
      end else if (count >= cfg.period) begin  // Period is period+1 cycles
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // Window chains off the previous close edge, up to cpmg steps
   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         cpmg_start <= '0;
         cpmg_end   <= '0;
         cpmg_idx   <= '0;
      end else if (cycle_start) begin
         cpmg_start <= cfg.sync_up + cfg.delay;  // First window after pulse 2
         cpmg_end   <= cfg.sync_up + cfg.delay + cfg.p2width;
         cpmg_idx   <= '0;
      end else if ((count == cpmg_end) && (cpmg_idx < cfg.cpmg)) begin
         cpmg_start <= cpmg_end + cfg.delay;
         cpmg_end   <= cpmg_end + cfg.delay + cfg.p2width;
         cpmg_idx   <= cpmg_idx + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: pulse_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_sequencer import pulse_pkg::*; (
   input  logic        clk_pll,
   input  logic        resetn,      // Reset asserted high
   pulse_cfg_if.dst    cfg,
   input  pulse_time_t count,
   input  pulse_time_t cpmg_start,
   input  pulse_time_t cpmg_end,
   input  logic        pump_on,     // External, active low extra pulse
   output logic        sync_on,     // Scope trigger
   output logic        pulse_on     // Microwave switch
);

   logic        pump_meta;    // First synchronizer stage
   logic        pump_sync;    // Safe to use in clk_pll domain
   logic        cpmg_open;
   logic        offres_open;
   logic        pulse_next;
   pulse_time_t offres_start;

   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         pump_meta <= 1'b0;
         pump_sync <= 1'b0;
      end else begin
         pump_meta <= pump_on;
         pump_sync <= pump_meta;
      end
   end

   assign offres_start = cfg.offres_delay - cfg.pbwidth;
   // Both window edges are exclusive
   assign cpmg_open    = (cfg.cpmg != '0) && (count > cpmg_start) && (count < cpmg_end);
   assign offres_open  = cfg.double && (count > offres_start) && (count < cfg.offres_delay);

   always_comb begin
      if (count < cfg.p1width) begin
         pulse_next = cfg.pump;      // Pump pulse only when enabled
      end else if (count < cfg.p2start) begin
         pulse_next = 1'b0;          // Gap between pulses
      end else if (count < cfg.sync_up) begin
         pulse_next = 1'b1;          // Probe pulse
      end else if (cpmg_open) begin
         pulse_next = 1'b1;          // CPMG echo train
      end else if (offres_open) begin
         pulse_next = !pump_sync;    // Extra pulse unless held off externally
      end else begin
         pulse_next = 1'b0;
      end
   end

   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         sync_on  <= 1'b0;
         pulse_on <= 1'b0;
      end else begin
         sync_on  <= (count < cfg.sync_up);  // High from period start to end of pulse 2
         pulse_on <= pulse_next;
      end
   end

endmodule

`default_nettype wire

// File: pulse_att_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_att_ctrl import pulse_pkg::*; (
   input  logic        clk_pll,
   input  logic        resetn,  // Reset asserted high
   pulse_cfg_if.dst    cfg,
   input  pulse_time_t count,
   output att_code_t   att1,    // Main attenuator
   output att_code_t   att3,    // Second attenuator
   output logic        inhib    // Blocking switch
);

   pulse_time_t probe_open;   // Main attenuator leaves pump setting after this
   pulse_time_t att3_open;    // Second attenuator opens here
   pulse_time_t block_open;   // Blocking switch releases here
   logic        after_down;   // Past the probe window, everything back to idle

   assign probe_open = cfg.p1width + 1'b1;
   assign att3_open  = cfg.sync_up - att3_lead;  // Opens ahead of the end of sync
   assign block_open = cfg.sync_up + pulse_time_t'(cfg.pulse_block);
   assign after_down = (count > cfg.att_down);

   always_ff @(posedge clk_pll) begin
      if (resetn) begin
         att1  <= '0;
         att3  <= '0;
         inhib <= 1'b0;
      end else begin
         att1  <= ((count < probe_open) || after_down) ? cfg.pp_pump : cfg.pp_probe;
         att3  <= ((count < att3_open) || after_down) ? cfg.post_att : '0;
         inhib <= ((count < block_open) || after_down) ? cfg.block : 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: pulse_top.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_top import pulse_pkg::*; (
   input  logic       clk_pll,    // 200 MHz
   input  logic       resetn,     // Reset asserted high
   input  axi_addr_t  s_awaddr,
   input  logic       s_awvalid,
   output logic       s_awready,
   input  axi_data_t  s_wdata,
   input  logic [3:0] s_wstrb,
   input  logic       s_wvalid,
   output logic       s_wready,
   output axi_resp_t  s_bresp,
   output logic       s_bvalid,
   input  logic       s_bready,
   input  axi_addr_t  s_araddr,
   input  logic       s_arvalid,
   output logic       s_arready,
   output axi_data_t  s_rdata,
   output axi_resp_t  s_rresp,
   output logic       s_rvalid,
   input  logic       s_rready,
   input  logic       pump_on,    // Async external input
   output logic       sync_on,
   output logic       pulse_on,
   output att_code_t  att1,
   output att_code_t  att3,
   output logic       inhib
);

   pulse_time_t count;
   logic        cycle_start;
   pulse_time_t cpmg_start;
   pulse_time_t cpmg_end;

   pulse_cfg_if cfg_if ();  // Committed settings

   pulse_regs u_regs (
      .clk_pll     (clk_pll),
      .resetn      (resetn),
      .s_awaddr    (s_awaddr),
      .s_awvalid   (s_awvalid),
      .s_awready   (s_awready),
      .s_wdata     (s_wdata),
      .s_wstrb     (s_wstrb),
      .s_wvalid    (s_wvalid),
      .s_wready    (s_wready),
      .s_bresp     (s_bresp),
      .s_bvalid    (s_bvalid),
      .s_bready    (s_bready),
      .s_araddr    (s_araddr),
      .s_arvalid   (s_arvalid),
      .s_arready   (s_arready),
      .s_rdata     (s_rdata),
      .s_rresp     (s_rresp),
      .s_rvalid    (s_rvalid),
      .s_rready    (s_rready),
      .cycle_start (cycle_start),
      .cfg         (cfg_if.src)
   );

   pulse_timer u_timer (
      .clk_pll     (clk_pll),
      .resetn      (resetn),
      .cfg         (cfg_if.dst),
      .count       (count),
      .cycle_start (cycle_start),
      .cpmg_start  (cpmg_start),
      .cpmg_end    (cpmg_end)
   );

   pulse_sequencer u_sequencer (
      .clk_pll    (clk_pll),
      .resetn     (resetn),
      .cfg        (cfg_if.dst),
      .count      (count),
      .cpmg_start (cpmg_start),
      .cpmg_end   (cpmg_end),
      .pump_on    (pump_on),
      .sync_on    (sync_on),
      .pulse_on   (pulse_on)
   );

   pulse_att_ctrl u_att_ctrl (
      .clk_pll (clk_pll),
      .resetn  (resetn),
      .cfg     (cfg_if.dst),
      .count   (count),
      .att1    (att1),
      .att3    (att3),
      .inhib   (inhib)
   );

endmodule

`default_nettype wire

// File: tb_pulse_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pulse_top import pulse_pkg::*; ();

   logic       clk_pll;
   logic       resetn;       // Reset asserted high
   axi_addr_t  s_awaddr;
   logic       s_awvalid;
   logic       s_awready;
   axi_data_t  s_wdata;
   logic [3:0] s_wstrb;
   logic       s_wvalid;
   logic       s_wready;
   axi_resp_t  s_bresp;
   logic       s_bvalid;
   logic       s_bready;
   axi_addr_t  s_araddr;
   logic       s_arvalid;
   logic       s_arready;
   axi_data_t  s_rdata;
   axi_resp_t  s_rresp;
   logic       s_rvalid;
   logic       s_rready;
   logic       pump_on;
   logic       sync_on;
   logic       pulse_on;
   att_code_t  att1;
   att_code_t  att3;
   logic       inhib;

   integer      seed = 32'ha496_dc19;
   int          errors = 0;
   bit          check_on = 1'b0;  // Model compare enabled after reset
   int          periods [10];     // One period per scenario plus one for the register test

   // Reference model state matches the DUT state after the latest rising edge
   pulse_time_t m_count;
   pulse_time_t m_cs;             // CPMG window open edge
   pulse_time_t m_ce;             // CPMG window close edge
   cpmg_count_t m_idx;
   axi_data_t   m_shadow [12];
   axi_data_t   m_commit [12];    // Committed words in register map layout
   logic        m_meta;
   logic        m_sync;
   logic        m_resp;           // Write response pending
   logic        m_rd;             // Read data pending
   logic        m_aw_taken;
   logic        m_w_taken;
   axi_addr_t   m_aw_addr;
   axi_data_t   m_w_data;
   logic [3:0]  m_w_strb;
   logic        m_sync_on;
   logic        m_pulse_on;
   att_code_t   m_att1;
   att_code_t   m_att3;
   logic        m_inhib;

   pulse_top u_dut (.*);

   initial begin
      clk_pll = 1'b0;
      forever #5 clk_pll = ~clk_pll;  // 100 MHz in simulation
   end

   function automatic int pick(input int lo, input int hi);
      return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   // Word aligned and inside the twelve mapped words
   function automatic logic is_mapped(input axi_addr_t addr);
      return (addr[1:0] == 2'b00) && (addr < 8'h30);
   endfunction

   function automatic axi_data_t merge_strobes(input axi_data_t old, input axi_data_t data,
                                               input logic [3:0] strb);
      axi_data_t res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
      end
      return res;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("FAIL %s expected %h actual %h at %0t", name, exp, got, $time);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_pll);
      #1;  // Inputs move just after the edge
   endtask

   // Compare the last edge and step the model through the coming edge
   always @(negedge clk_pll) begin
      logic        at_start;
      logic        late;
      logic        aw_fire;
      logic        w_fire;
      axi_addr_t   waddr;
      pulse_time_t sync_up;
      pulse_time_t offres_start;
      if (check_on) begin
         check_value("sync_on", sync_on, m_sync_on);
         check_value("pulse_on", pulse_on, m_pulse_on);
         check_value("att1", att1, m_att1);
         check_value("att3", att3, m_att3);
         check_value("inhib", inhib, m_inhib);
         check_value("s_awready", s_awready, !m_resp && !m_aw_taken);
         check_value("s_wready", s_wready, !m_resp && !m_w_taken);
         check_value("s_bvalid", s_bvalid, m_resp);
         check_value("s_arready", s_arready, !m_rd);
         check_value("s_rvalid", s_rvalid, m_rd);
      end
      if (resetn) begin
         m_count    = '0;
         m_cs       = '0;
         m_ce       = '0;
         m_idx      = '0;
         m_meta     = 1'b0;
         m_sync     = 1'b0;
         m_resp     = 1'b0;
         m_rd       = 1'b0;
         m_aw_taken = 1'b0;
         m_w_taken  = 1'b0;
         m_sync_on  = 1'b0;
         m_pulse_on = 1'b0;
         m_att1     = '0;
         m_att3     = '0;
         m_inhib    = 1'b0;
         for (int k = 0; k < 12; k++) begin
            m_shadow[k] = '0;
            m_commit[k] = '0;
         end
      end else begin
         at_start     = (m_count == '0);
         sync_up      = m_commit[2];
         late         = (m_count > m_commit[7]);             // Past att_down
         offres_start = m_commit[10] - m_commit[6];          // offres_delay minus pbwidth
         m_sync_on    = (m_count < sync_up);
         if (m_count < m_commit[3]) m_pulse_on = m_commit[0][0];  // Pump pulse
         else if (m_count < m_commit[4]) m_pulse_on = 1'b0;
         else if (m_count < sync_up) m_pulse_on = 1'b1;           // Probe pulse
         else if ((m_commit[11][15:8] != 0) && (m_count > m_cs) && (m_count < m_ce))
            m_pulse_on = 1'b1;
         else if (m_commit[0][1] && (m_count > offres_start) && (m_count < m_commit[10]))
            m_pulse_on = !m_sync;
         else m_pulse_on = 1'b0;
         m_att1  = ((m_count < m_commit[3] + 32'd1) || late) ? m_commit[8][6:0] : m_commit[8][14:8];
         m_att3  = ((m_count < sync_up - att3_lead) || late) ? m_commit[8][22:16] : 7'd0;
         m_inhib = ((m_count < sync_up + pulse_time_t'(m_commit[11][7:0])) || late) ?
                   m_commit[0][2] : 1'b0;
         if (at_start) begin
            m_cs  = sync_up + m_commit[9];                  // sync_up plus delay
            m_ce  = sync_up + m_commit[9] + m_commit[5];
            m_idx = '0;
         end else if ((m_count == m_ce) && (m_idx < m_commit[11][15:8])) begin
            m_cs  = m_ce + m_commit[9];
            m_ce  = m_ce + m_commit[9] + m_commit[5];
            m_idx = m_idx + 1'b1;
         end
         m_count = (m_count == m_commit[1]) ? '0 : m_count + 1'b1;
         if (at_start) m_commit = m_shadow;                 // Shadow before this edge's write
         m_sync = m_meta;
         m_meta = pump_on;
         aw_fire = s_awvalid && !m_resp && !m_aw_taken;
         w_fire  = s_wvalid && !m_resp && !m_w_taken;
         if (m_resp) begin
            if (s_bready) m_resp = 1'b0;
         end else if ((m_aw_taken || aw_fire) && (m_w_taken || w_fire)) begin
            waddr = m_aw_taken ? m_aw_addr : s_awaddr;
            if (is_mapped(waddr)) begin
               m_shadow[waddr[5:2]] = merge_strobes(m_shadow[waddr[5:2]],
                  m_w_taken ? m_w_data : s_wdata, m_w_taken ? m_w_strb : s_wstrb);
            end
            m_resp     = 1'b1;
            m_aw_taken = 1'b0;
            m_w_taken  = 1'b0;
         end else begin
            if (aw_fire) begin
               m_aw_taken = 1'b1;
               m_aw_addr  = s_awaddr;
            end
            if (w_fire) begin
               m_w_taken = 1'b1;
               m_w_data  = s_wdata;
               m_w_strb  = s_wstrb;
            end
         end
         if (m_rd) begin
            if (s_rready) m_rd = 1'b0;  // Data taken
         end else if (s_arvalid) begin
            m_rd = 1'b1;
         end
      end
   end

   task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input logic [3:0] strb,
                            input axi_resp_t exp_resp);
      int   aw_wait;
      int   w_wait;
      int   guard;
      logic aw_done;
      logic w_done;
      logic aw_fire;
      logic w_fire;
      logic got;
      aw_wait  = pick(0, 2);  // Either channel may lead
      w_wait   = pick(0, 2);
      aw_done  = 1'b0;
      w_done   = 1'b0;
      guard    = 0;
      s_awaddr = addr;
      s_wdata  = data;
      s_wstrb  = strb;
      while (!(aw_done && w_done) && (guard < 20)) begin
         if (!aw_done && (aw_wait == 0)) s_awvalid = 1'b1;
         if (!w_done && (w_wait == 0)) s_wvalid = 1'b1;
         @(negedge clk_pll);
         aw_fire = s_awvalid && s_awready;
         w_fire  = s_wvalid && s_wready;
         next_cycle();
         if (aw_fire) begin
            aw_done   = 1'b1;
            s_awvalid = 1'b0;
         end
         if (w_fire) begin
            w_done   = 1'b1;
            s_wvalid = 1'b0;
         end
         if (aw_wait > 0) aw_wait--;
         if (w_wait > 0) w_wait--;
         guard++;
      end
      assert (aw_done && w_done) else begin
         errors++;
         $display("Write to %h was not accepted", addr);
      end
      repeat (pick(0, 3)) next_cycle();  // Response must wait
      s_bready = 1'b1;
      guard    = 0;
      do begin
         @(negedge clk_pll);
         got = s_bvalid;
         if (got) check_value("s_bresp", s_bresp, exp_resp);
         next_cycle();
         guard++;
      end while (!got && (guard < 20));
      s_bready = 1'b0;
      assert (got) else begin
         errors++;
         $display("Write to %h got no response", addr);
      end
   endtask

   task automatic axi_read(input axi_addr_t addr, input axi_data_t exp_data,
                           input axi_resp_t exp_resp);
      int   guard;
      logic fire;
      logic got;
      s_araddr  = addr;
      s_arvalid = 1'b1;
      guard     = 0;
      do begin
         @(negedge clk_pll);
         fire = s_arready;
         next_cycle();
         guard++;
      end while (!fire && (guard < 20));
      s_arvalid = 1'b0;
      assert (fire) else begin
         errors++;
         $display("Read of %h was not accepted", addr);
      end
      repeat (pick(0, 3)) next_cycle();
      s_rready = 1'b1;
      guard    = 0;
      do begin
         @(negedge clk_pll);
         got = s_rvalid;
         if (got) begin
            check_value("s_rdata", s_rdata, exp_data);
            check_value("s_rresp", s_rresp, exp_resp);
         end
         next_cycle();
         guard++;
      end while (!got && (guard < 20));
      s_rready = 1'b0;
      assert (got) else begin
         errors++;
         $display("Read of %h got no data", addr);
      end
   endtask

   // Edges ordered as p1width < p2start < sync_up < att_down < period
   task automatic write_config(input int period, input bit pump, input bit dbl, input bit blk,
                               input int n_cpmg);
      axi_data_t w [12];
      w[0]  = {29'd0, blk, dbl, pump};
      w[1]  = period;
      w[3]  = pick(4, 15);
      w[4]  = w[3] + pick(4, 15);
      w[2]  = w[4] + pick(30, 49);                    // Past att3_lead
      w[5]  = pick(2, 7);                             // p2width
      w[6]  = pick(4, 13);                            // pbwidth
      w[7]  = w[2] + pick(20, period - w[2] - 40);
      w[8]  = $random(seed) & 32'h007f_7f7f;
      w[9]  = pick(3, 10);                            // CPMG gap
      w[10] = period - pick(5, 14);                   // Extra pulse near period end
      w[11] = (n_cpmg << 8) | pick(0, 31);
      for (int k = 0; k < 12; k++) axi_write(axi_addr_t'(4 * k), w[k], 4'hf, resp_okay);
   endtask

   task automatic run_periods(input int n, input bit count_windows, input int exp_windows,
                              input bit drive_pump);
      int   done;
      int   rises;
      logic prev;
      while (m_count != '0) next_cycle();  // Align to a period start
      done  = 0;
      rises = 0;
      prev  = pulse_on;
      while (done < n) begin
         next_cycle();
         if (!sync_on && pulse_on && !prev) rises++;  // Pulses after the probe
         prev = pulse_on;
         if (m_count == '0) begin
            if (count_windows && (done > 0)) check_value("cpmg windows", rises, exp_windows);
            rises = 0;
            done++;
            if (drive_pump) pump_on = !pump_on;  // Far from the extra pulse
         end
      end
   endtask

   task automatic test_registers();
      axi_data_t  wrote [12];
      axi_data_t  data;
      logic [3:0] strb;
      for (int k = 0; k < 12; k++) begin
         wrote[k] = (k == 1) ? periods[9] : $random(seed);
         axi_write(axi_addr_t'(4 * k), wrote[k], 4'hf, resp_okay);
      end
      for (int k = 0; k < 12; k++) axi_read(axi_addr_t'(4 * k), wrote[k], resp_okay);
      data  = $random(seed);
      strb  = pick(1, 14);
      wrote[8] = merge_strobes(wrote[8], data, strb);
      axi_write(reg_att, data, strb, resp_okay);
      axi_read(reg_att, wrote[8], resp_okay);
      axi_write(8'h30, $random(seed), 4'hf, resp_slverr);
      axi_write(8'h06, $random(seed), 4'hf, resp_slverr);  // Misaligned
      axi_read(8'h34, '0, resp_slverr);
      axi_read(8'hfc, '0, resp_slverr);
      for (int k = 0; k < 12; k++) axi_read(axi_addr_t'(4 * k), wrote[k], resp_okay);
   endtask

   initial begin
      int total;
      int watchdog_ns;
      resetn    = 1'b1;
      s_awaddr  = '0;
      s_awvalid = 1'b0;
      s_wdata   = '0;
      s_wstrb   = '0;
      s_wvalid  = 1'b0;
      s_bready  = 1'b0;
      s_araddr  = '0;
      s_arvalid = 1'b0;
      s_rready  = 1'b0;
      pump_on   = 1'b0;
      total     = 0;
      for (int i = 0; i < 10; i++) begin
         periods[i] = pick(200, 600);
         total += periods[i];
      end
      watchdog_ns = (20 * total + 20000) * 10;  // Extra cycles cover AXI traffic
      fork
         begin
            #(watchdog_ns);
            $display("Timeout: run still busy after %0d ns", watchdog_ns);
            $display("sim failed");
            $finish;
         end
      join_none
      repeat (16) next_cycle();
      resetn   = 1'b0;
      check_on = 1'b1;
      test_registers();
      write_config(periods[0], 1'b1, 1'b0, 1'b1, 0);  // Pump set
      run_periods(3, 1'b0, 0, 1'b0);
      write_config(periods[1], 1'b0, 1'b0, 1'b1, 0);  // Pump clear
      run_periods(3, 1'b0, 0, 1'b0);
      for (int c = 1; c <= 4; c++) begin
         write_config(periods[1 + c], c % 2, 1'b0, 1'b1, c);
         run_periods(3, 1'b1, c + 1, 1'b0);
      end
      write_config(periods[6], 1'b1, 1'b0, 1'b0, pick(0, 2));  // Blocking off
      run_periods(2, 1'b0, 0, 1'b0);
      write_config(periods[7], 1'b1, 1'b1, 1'b1, 0);  // Extra pulse
      run_periods(4, 1'b0, 0, 1'b1);
      pump_on = 1'b0;
      while (m_count != 32'd20) next_cycle();  // Writes land mid-period
      write_config(periods[8], 1'b0, 1'b1, 1'b0, 2);
      run_periods(3, 1'b0, 0, 1'b0);
      repeat (4) next_cycle();
      $display("Checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
pulse_pkg.sv
pulse_cfg_if.sv
pulse_regs.sv
pulse_timer.sv
pulse_sequencer.sv
pulse_att_ctrl.sv
pulse_top.sv
tb_pulse_top.sv

// File: Bender.yml
package:
  name: pulse_timing

sources:
  - pulse_pkg.sv
  - pulse_cfg_if.sv
  - pulse_regs.sv
  - pulse_timer.sv
  - pulse_sequencer.sv
  - pulse_att_ctrl.sv
  - pulse_top.sv
  - target: test
    files:
      - tb_pulse_top.sv
